// ==== src/l15_adapter_settings.svh ====
// Fixed one-beat L1.5 port; L15_TAG_W must equal L15_PORT_W + L15_ID_W
`ifndef L15_ADAPTER_SETTINGS_SVH
`define L15_ADAPTER_SETTINGS_SVH

`define L15_ADDR_W        32
`define L15_DATA_W        64
`define L15_LINE_W        128
`define L15_ID_W          4
`define L15_PORT_W        2
`define L15_TAG_W         6
`define L15_SIZE_W        3
`define L15_CREDITS       2

// Requester ports carried in the tag
`define L15_PORT_IFILL    2'd0
`define L15_PORT_READ     2'd1
`define L15_PORT_WRITE    2'd2

// L1.5 request and return type codes
`define L15_RQ_LOAD       3'd0
`define L15_RQ_STORE      3'd1
`define L15_RQ_IFILL      3'd4
`define L15_RT_LOAD       3'd0
`define L15_RT_IFILL      3'd1
`define L15_RT_STORE_ACK  3'd4

`endif

// ==== src/l15_adapter_pkg.sv ====
// Tag layout is port above id; the L1.5 side must echo the raw word unchanged
`include "l15_adapter_settings.svh"

package l15_adapter_pkg;

  // Transaction tag, opaque on the L1.5 side
  typedef union packed {
    logic [`L15_TAG_W-1:0] raw;
    struct packed {
      logic [`L15_PORT_W-1:0] port;
      logic [`L15_ID_W-1:0]   id;
    } fields;
  } l15_tag_u;

endpackage

// ==== src/l15_mem_if.sv ====
// Valid/ready channels; a source holds its fields while valid is high and ready low
`include "l15_adapter_settings.svh"

interface l15_req_if;
  import l15_adapter_pkg::*;

  logic                   valid;
  logic                   ready;
  logic [`L15_ADDR_W-1:0] addr;
  logic [`L15_SIZE_W-1:0] size;
  logic [2:0]             rtype;
  l15_tag_u               tag;
  logic [`L15_DATA_W-1:0] data;

  modport src (output valid, addr, size, rtype, tag, data, input ready);
  modport dst (input valid, addr, size, rtype, tag, data, output ready);

endinterface

interface l15_resp_if;
  import l15_adapter_pkg::*;

  logic                   valid;
  logic                   ready;
  l15_tag_u               tag;
  logic [2:0]             rtype;
  logic [`L15_LINE_W-1:0] data;

  modport src (output valid, tag, rtype, data, input ready);
  modport dst (input valid, tag, rtype, data, output ready);

endinterface

// ==== src/icache_fill_bridge.sv ====
// One miss in flight in the buffer; refill side has no back-pressure
`include "l15_adapter_settings.svh"

module icache_fill_bridge (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            miss_valid_i,
  output logic                            miss_ready_o,
  input  logic [`L15_ADDR_W-1:0]          miss_paddr_i,
  input  logic                            miss_nc_i,
  input  logic [`L15_ID_W-1:0]            miss_tid_i,
  l15_req_if.src                          req,
  input  logic                            ifill_resp_valid_i,
  input  logic [`L15_LINE_W-1:0]          ifill_resp_data_i,
  input  l15_adapter_pkg::l15_tag_u       ifill_resp_tag_i,
  output logic                            icache_resp_valid_o,
  output logic [`L15_LINE_W-1:0]          icache_resp_data_o,
  output logic [`L15_ID_W-1:0]            icache_resp_tid_o
);
  import l15_adapter_pkg::*;

  // log2 of the byte count
  localparam logic [`L15_SIZE_W-1:0] SIZE_WORD = 3;
  localparam logic [`L15_SIZE_W-1:0] SIZE_LINE = 4;

  logic                   full_q;
  logic [`L15_ADDR_W-1:0] paddr_q;
  logic [`L15_SIZE_W-1:0] size_q;
  logic [`L15_ID_W-1:0]   tid_q;
  l15_tag_u               tag_d;

  assign miss_ready_o = ~full_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (miss_valid_i && !full_q) begin
      full_q <= 1'b1;
    end else if (req.valid && req.ready) begin
      full_q <= 1'b0;
    end
  end

  // Payload captured only while empty
  always_ff @(posedge clk_i) begin
    if (miss_valid_i && !full_q) begin
      paddr_q <= miss_paddr_i;
      size_q  <= miss_nc_i ? SIZE_WORD : SIZE_LINE;
      tid_q   <= miss_tid_i;
    end
  end

  always_comb begin
    tag_d.fields.port = `L15_PORT_IFILL;
    tag_d.fields.id   = tid_q;
  end

  assign req.valid = full_q;
  assign req.addr  = paddr_q;
  assign req.size  = size_q;
  assign req.rtype = `L15_RQ_IFILL;
  assign req.tag   = tag_d;
  assign req.data  = '0;

  // Refill line goes straight back with its tid
  assign icache_resp_valid_o = ifill_resp_valid_i;
  assign icache_resp_data_o  = ifill_resp_data_i;
  assign icache_resp_tid_o   = ifill_resp_tag_i.fields.id;

endmodule

// ==== src/l15_req_arbiter.sv ====
// Three fixed requesters; a write is eligible only together with its data strobe
`include "l15_adapter_settings.svh"

module l15_req_arbiter (
  input  logic   clk_i,
  input  logic   rst_i,
  l15_req_if.dst ifill,
  l15_req_if.dst rd,
  l15_req_if.dst wr,
  input  logic   wr_data_valid_i,
  l15_req_if.src arb
);

  localparam int NREQ = 3;

  logic [NREQ-1:0] elig;
  logic [NREQ-1:0] rr_gnt;
  logic [NREQ-1:0] gnt;
  logic [NREQ-1:0] gnt_q;
  logic            hold_q;
  logic [1:0]      ptr_q;
  logic [1:0]      win;

  assign elig = {wr.valid & wr_data_valid_i, rd.valid, ifill.valid};

  // Search from the pointer; the lowest offset wins
  always_comb begin
    int unsigned j;
    rr_gnt = '0;
    for (int k = NREQ - 1; k >= 0; k--) begin
      j = ptr_q + k;
      if (j >= NREQ) begin
        j = j - NREQ;
      end
      if (elig[j]) begin
        rr_gnt = NREQ'(1) << j;
      end
    end
  end

  // Keep a stalled grant so the offered request stays stable
  assign gnt = (hold_q && |(gnt_q & elig)) ? gnt_q : rr_gnt;

  always_comb begin
    win = '0;
    for (int k = 0; k < NREQ; k++) begin
      if (gnt[k]) begin
        win = 2'(k);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q  <= '0;
      hold_q <= 1'b0;
      gnt_q  <= '0;
    end else begin
      hold_q <= arb.valid & ~arb.ready;
      gnt_q  <= gnt;
      if (arb.valid && arb.ready) begin
        ptr_q <= (win == 2'(NREQ - 1)) ? 2'd0 : win + 2'd1;
      end
    end
  end

  assign arb.valid = |gnt;

  always_comb begin
    arb.addr  = ifill.addr;
    arb.size  = ifill.size;
    arb.rtype = ifill.rtype;
    arb.tag   = ifill.tag;
    arb.data  = ifill.data;
    if (gnt[1]) begin
      arb.addr  = rd.addr;
      arb.size  = rd.size;
      arb.rtype = rd.rtype;
      arb.tag   = rd.tag;
      arb.data  = rd.data;
    end else if (gnt[2]) begin
      arb.addr  = wr.addr;
      arb.size  = wr.size;
      arb.rtype = wr.rtype;
      arb.tag   = wr.tag;
      arb.data  = wr.data;
    end
  end

  // Only the winner sees ready
  assign ifill.ready = gnt[0] & arb.ready;
  assign rd.ready    = gnt[1] & arb.ready;
  assign wr.ready    = gnt[2] & arb.ready;

endmodule

// ==== src/l15_bridge.sv ====
// Return buffer depth equals L15_CREDITS, so L1.5 returns never need back-pressure
`include "l15_adapter_settings.svh"

module l15_bridge (
  input  logic                   clk_i,
  input  logic                   rst_i,
  l15_req_if.dst                 req,
  l15_resp_if.src                resp,
  output logic                   l15_val_o,
  input  logic                   l15_ack_i,
  output logic [2:0]             l15_rqtype_o,
  output logic [`L15_SIZE_W-1:0] l15_size_o,
  output logic [`L15_ADDR_W-1:0] l15_address_o,
  output logic [`L15_DATA_W-1:0] l15_data_o,
  output logic [`L15_TAG_W-1:0]  l15_tag_o,
  input  logic                   l15_rtrn_val_i,
  input  logic [2:0]             l15_rtrn_type_i,
  input  logic [`L15_TAG_W-1:0]  l15_rtrn_tag_i,
  input  logic [`L15_LINE_W-1:0] l15_rtrn_data_i
);
  import l15_adapter_pkg::*;

  localparam int DEPTH = `L15_CREDITS;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int PTR_W = $clog2(DEPTH);

  logic                   req_fire;
  logic                   resp_fire;
  logic                   val_q;
  logic [CNT_W-1:0]       outst_q;
  logic [2:0]             rqtype_q;
  logic [`L15_SIZE_W-1:0] size_q;
  logic [`L15_ADDR_W-1:0] addr_q;
  logic [`L15_DATA_W-1:0] data_q;
  l15_tag_u               tag_q;

  logic [2:0]             rt_type_q [DEPTH];
  l15_tag_u               rt_tag_q  [DEPTH];
  logic [`L15_LINE_W-1:0] rt_data_q [DEPTH];
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [CNT_W-1:0]       fill_q;

  assign req_fire  = req.valid & req.ready;
  assign resp_fire = resp.valid & resp.ready;

  // No new request while one waits for ack or credits are used up
  assign req.ready = ~val_q & (outst_q < CNT_W'(DEPTH));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      val_q   <= 1'b0;
      outst_q <= '0;
    end else begin
      if (req_fire) begin
        val_q <= 1'b1;
      end else if (val_q && l15_ack_i) begin
        val_q <= 1'b0;
      end
      // Credit returns when the buffered response leaves
      outst_q <= outst_q + CNT_W'(req_fire) - CNT_W'(resp_fire);
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rqtype_q <= req.rtype;
      size_q   <= req.size;
      addr_q   <= req.addr;
      data_q   <= req.data;
      tag_q    <= req.tag;
    end
  end

  assign l15_val_o     = val_q;
  assign l15_rqtype_o  = rqtype_q;
  assign l15_size_o    = size_q;
  assign l15_address_o = addr_q;
  assign l15_data_o    = data_q;
  assign l15_tag_o     = tag_q.raw;

  // Return FIFO
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (l15_rtrn_val_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (resp_fire) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      fill_q <= fill_q + CNT_W'(l15_rtrn_val_i) - CNT_W'(resp_fire);
    end
  end

  always_ff @(posedge clk_i) begin
    if (l15_rtrn_val_i) begin
      rt_type_q[wr_ptr_q]     <= l15_rtrn_type_i;
      rt_tag_q[wr_ptr_q].raw  <= l15_rtrn_tag_i;
      rt_data_q[wr_ptr_q]     <= l15_rtrn_data_i;
    end
  end

  assign resp.valid = (fill_q != '0);
  assign resp.rtype = rt_type_q[rd_ptr_q];
  assign resp.tag   = rt_tag_q[rd_ptr_q];
  assign resp.data  = rt_data_q[rd_ptr_q];

endmodule

// ==== src/l15_resp_demux.sv ====
// Returns whose type disagrees with their tag port are dropped
`include "l15_adapter_settings.svh"

module l15_resp_demux (
  l15_resp_if.dst                   resp,
  output logic                      ifill_valid_o,
  output logic [`L15_LINE_W-1:0]    ifill_data_o,
  output l15_adapter_pkg::l15_tag_u ifill_tag_o,
  output logic                      rd_valid_o,
  input  logic                      rd_ready_i,
  output logic [`L15_DATA_W-1:0]    rd_data_o,
  output logic [`L15_ID_W-1:0]      rd_id_o,
  output logic                      wr_valid_o,
  input  logic                      wr_ready_i,
  output logic [`L15_ID_W-1:0]      wr_id_o
);

  logic [`L15_PORT_W-1:0] port;
  logic                   to_ifill;
  logic                   to_rd;
  logic                   to_wr;

  assign port     = resp.tag.fields.port;
  assign to_ifill = (port == `L15_PORT_IFILL) && (resp.rtype == `L15_RT_IFILL);
  assign to_rd    = (port == `L15_PORT_READ)  && (resp.rtype == `L15_RT_LOAD);
  assign to_wr    = (port == `L15_PORT_WRITE) && (resp.rtype == `L15_RT_STORE_ACK);

  assign ifill_valid_o = resp.valid & to_ifill;
  assign ifill_data_o  = resp.data;
  assign ifill_tag_o   = resp.tag;

  assign rd_valid_o = resp.valid & to_rd;
  assign rd_data_o  = resp.data[`L15_DATA_W-1:0];
  assign rd_id_o    = resp.tag.fields.id;

  assign wr_valid_o = resp.valid & to_wr;
  assign wr_id_o    = resp.tag.fields.id;

  // Refill side and dropped returns never stall
  assign resp.ready = to_rd ? rd_ready_i : (to_wr ? wr_ready_i : 1'b1);

endmodule

// ==== src/l15_adapter_top.sv ====
// Single-beat transfers only; at most L15_CREDITS transactions outstanding on the L1.5
`include "l15_adapter_settings.svh"

module l15_adapter_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // Instruction cache
  input  logic                   icache_miss_valid_i,
  output logic                   icache_miss_ready_o,
  input  logic [`L15_ADDR_W-1:0] icache_miss_paddr_i,
  input  logic                   icache_miss_nc_i,
  input  logic [`L15_ID_W-1:0]   icache_miss_tid_i,
  output logic                   icache_resp_valid_o,
  output logic [`L15_LINE_W-1:0] icache_resp_data_o,
  output logic [`L15_ID_W-1:0]   icache_resp_tid_o,
  // Data cache read miss
  input  logic                   dcache_rd_valid_i,
  output logic                   dcache_rd_ready_o,
  input  logic [`L15_ADDR_W-1:0] dcache_rd_addr_i,
  input  logic [`L15_SIZE_W-1:0] dcache_rd_size_i,
  input  logic [`L15_ID_W-1:0]   dcache_rd_id_i,
  // Data cache write buffer
  input  logic                   dcache_wr_valid_i,
  output logic                   dcache_wr_ready_o,
  input  logic [`L15_ADDR_W-1:0] dcache_wr_addr_i,
  input  logic [`L15_SIZE_W-1:0] dcache_wr_size_i,
  input  logic [`L15_ID_W-1:0]   dcache_wr_id_i,
  input  logic                   dcache_wdata_valid_i,
  output logic                   dcache_wdata_ready_o,
  input  logic [`L15_DATA_W-1:0] dcache_wdata_i,
  // Data cache responses
  output logic                   dcache_rd_resp_valid_o,
  input  logic                   dcache_rd_resp_ready_i,
  output logic [`L15_DATA_W-1:0] dcache_rd_resp_data_o,
  output logic [`L15_ID_W-1:0]   dcache_rd_resp_id_o,
  output logic                   dcache_wr_resp_valid_o,
  input  logic                   dcache_wr_resp_ready_i,
  output logic [`L15_ID_W-1:0]   dcache_wr_resp_id_o,
  // L1.5
  output logic                   l15_val_o,
  input  logic                   l15_ack_i,
  output logic [2:0]             l15_rqtype_o,
  output logic [`L15_SIZE_W-1:0] l15_size_o,
  output logic [`L15_ADDR_W-1:0] l15_address_o,
  output logic [`L15_DATA_W-1:0] l15_data_o,
  output logic [`L15_TAG_W-1:0]  l15_tag_o,
  input  logic                   l15_rtrn_val_i,
  input  logic [2:0]             l15_rtrn_type_i,
  input  logic [`L15_TAG_W-1:0]  l15_rtrn_tag_i,
  input  logic [`L15_LINE_W-1:0] l15_rtrn_data_i
);
  import l15_adapter_pkg::*;

  logic                   ifill_valid;
  logic [`L15_LINE_W-1:0] ifill_data;
  l15_tag_u               ifill_tag;

  l15_req_if  ifill_req ();
  l15_req_if  rd_req ();
  l15_req_if  wr_req ();
  l15_req_if  arb_req ();
  l15_resp_if buf_resp ();

  // Read miss port
  assign rd_req.valid      = dcache_rd_valid_i;
  assign rd_req.addr       = dcache_rd_addr_i;
  assign rd_req.size       = dcache_rd_size_i;
  assign rd_req.rtype      = `L15_RQ_LOAD;
  assign rd_req.tag        = {`L15_PORT_READ, dcache_rd_id_i};
  assign rd_req.data       = '0;
  assign dcache_rd_ready_o = rd_req.ready;

  // Write buffer port, request and data accepted together
  assign wr_req.valid         = dcache_wr_valid_i;
  assign wr_req.addr          = dcache_wr_addr_i;
  assign wr_req.size          = dcache_wr_size_i;
  assign wr_req.rtype         = `L15_RQ_STORE;
  assign wr_req.tag           = {`L15_PORT_WRITE, dcache_wr_id_i};
  assign wr_req.data          = dcache_wdata_i;
  assign dcache_wr_ready_o    = wr_req.ready;
  assign dcache_wdata_ready_o = wr_req.ready;

  icache_fill_bridge u_ifill (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .miss_valid_i        (icache_miss_valid_i),
    .miss_ready_o        (icache_miss_ready_o),
    .miss_paddr_i        (icache_miss_paddr_i),
    .miss_nc_i           (icache_miss_nc_i),
    .miss_tid_i          (icache_miss_tid_i),
    .req                 (ifill_req.src),
    .ifill_resp_valid_i  (ifill_valid),
    .ifill_resp_data_i   (ifill_data),
    .ifill_resp_tag_i    (ifill_tag),
    .icache_resp_valid_o (icache_resp_valid_o),
    .icache_resp_data_o  (icache_resp_data_o),
    .icache_resp_tid_o   (icache_resp_tid_o)
  );

  l15_req_arbiter u_arb (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .ifill           (ifill_req.dst),
    .rd              (rd_req.dst),
    .wr              (wr_req.dst),
    .wr_data_valid_i (dcache_wdata_valid_i),
    .arb             (arb_req.src)
  );

  l15_bridge u_bridge (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .req             (arb_req.dst),
    .resp            (buf_resp.src),
    .l15_val_o       (l15_val_o),
    .l15_ack_i       (l15_ack_i),
    .l15_rqtype_o    (l15_rqtype_o),
    .l15_size_o      (l15_size_o),
    .l15_address_o   (l15_address_o),
    .l15_data_o      (l15_data_o),
    .l15_tag_o       (l15_tag_o),
    .l15_rtrn_val_i  (l15_rtrn_val_i),
    .l15_rtrn_type_i (l15_rtrn_type_i),
    .l15_rtrn_tag_i  (l15_rtrn_tag_i),
    .l15_rtrn_data_i (l15_rtrn_data_i)
  );

  l15_resp_demux u_demux (
    .resp          (buf_resp.dst),
    .ifill_valid_o (ifill_valid),
    .ifill_data_o  (ifill_data),
    .ifill_tag_o   (ifill_tag),
    .rd_valid_o    (dcache_rd_resp_valid_o),
    .rd_ready_i    (dcache_rd_resp_ready_i),
    .rd_data_o     (dcache_rd_resp_data_o),
    .rd_id_o       (dcache_rd_resp_id_o),
    .wr_valid_o    (dcache_wr_resp_valid_o),
    .wr_ready_i    (dcache_wr_resp_ready_i),
    .wr_id_o       (dcache_wr_resp_id_o)
  );

endmodule

// ==== tests/tb_l15_adapter.sv ====
// Read and write traffic use separate address regions; stimulus addresses are 8-byte aligned
`include "l15_adapter_settings.svh"

module tb_l15_adapter;
  timeunit 1ns;
  timeprecision 100ps;

  import l15_adapter_pkg::*;

  localparam int TIMEOUT = 400;
  localparam int CREDITS = `L15_CREDITS;
  localparam int N_RAND  = 24;

  typedef struct {
    logic [`L15_PORT_W-1:0] port;
    logic [`L15_ADDR_W-1:0] addr;
    logic [`L15_SIZE_W-1:0] size;
    logic [`L15_ID_W-1:0]   id;
    logic [`L15_DATA_W-1:0] data;
  } txn_t;

  typedef struct {
    logic [2:0]             rtype;
    logic [`L15_TAG_W-1:0]  tag;
    logic [`L15_LINE_W-1:0] data;
    int                     due;
  } rtrn_t;

  logic                   clk_i = 1'b0;
  logic                   rst_i;
  logic                   icache_miss_valid_i;
  logic                   icache_miss_ready_o;
  logic [`L15_ADDR_W-1:0] icache_miss_paddr_i;
  logic                   icache_miss_nc_i;
  logic [`L15_ID_W-1:0]   icache_miss_tid_i;
  logic                   icache_resp_valid_o;
  logic [`L15_LINE_W-1:0] icache_resp_data_o;
  logic [`L15_ID_W-1:0]   icache_resp_tid_o;
  logic                   dcache_rd_valid_i;
  logic                   dcache_rd_ready_o;
  logic [`L15_ADDR_W-1:0] dcache_rd_addr_i;
  logic [`L15_SIZE_W-1:0] dcache_rd_size_i;
  logic [`L15_ID_W-1:0]   dcache_rd_id_i;
  logic                   dcache_wr_valid_i;
  logic                   dcache_wr_ready_o;
  logic [`L15_ADDR_W-1:0] dcache_wr_addr_i;
  logic [`L15_SIZE_W-1:0] dcache_wr_size_i;
  logic [`L15_ID_W-1:0]   dcache_wr_id_i;
  logic                   dcache_wdata_valid_i;
  logic                   dcache_wdata_ready_o;
  logic [`L15_DATA_W-1:0] dcache_wdata_i;
  logic                   dcache_rd_resp_valid_o;
  logic                   dcache_rd_resp_ready_i = 1'b1;
  logic [`L15_DATA_W-1:0] dcache_rd_resp_data_o;
  logic [`L15_ID_W-1:0]   dcache_rd_resp_id_o;
  logic                   dcache_wr_resp_valid_o;
  logic                   dcache_wr_resp_ready_i = 1'b1;
  logic [`L15_ID_W-1:0]   dcache_wr_resp_id_o;
  logic                   l15_val_o;
  logic                   l15_ack_i = 1'b0;
  logic [2:0]             l15_rqtype_o;
  logic [`L15_SIZE_W-1:0] l15_size_o;
  logic [`L15_ADDR_W-1:0] l15_address_o;
  logic [`L15_DATA_W-1:0] l15_data_o;
  logic [`L15_TAG_W-1:0]  l15_tag_o;
  logic                   l15_rtrn_val_i = 1'b0;
  logic [2:0]             l15_rtrn_type_i = '0;
  logic [`L15_TAG_W-1:0]  l15_rtrn_tag_i = '0;
  logic [`L15_LINE_W-1:0] l15_rtrn_data_i = '0;

  integer seed       = 32'ha8adcf66;
  int     n_checks   = 0;
  int     n_errors   = 0;
  int     n_timeouts = 0;
  int     cycle_n    = 0;
  int     ack_wait   = -1;
  int     last_due   = 0;
  bit     toggle_en  = 1'b0;
  rtrn_t  rtrn_cur;

  // Accepted by a requester port, not yet seen on the L1.5
  txn_t issued_q[$];
  // Accepted, response not yet delivered
  txn_t waiting_q[$];
  // Acked by the L1.5 model, return not yet driven
  rtrn_t rtrn_q[$];
  logic [`L15_DATA_W-1:0] shadow [logic [`L15_ADDR_W-1:0]];

  l15_adapter_top dut0 (.*);

  always #5 clk_i = ~clk_i;

  // Unwritten words hold a pattern of their full address
  function automatic logic [`L15_DATA_W-1:0] mem_word(input logic [`L15_ADDR_W-1:0] a);
    if (shadow.exists(a)) begin
      return shadow[a];
    end
    return {a ^ 32'h9e37_79b9, {a[15:0], a[31:16]} ^ 32'h7f4a_7c15};
  endfunction

  // Return line, low word at the request address
  function automatic logic [`L15_LINE_W-1:0] ref_line(input logic [`L15_ADDR_W-1:0] a);
    return {mem_word(a + 32'd8), mem_word(a)};
  endfunction

  function automatic logic [`L15_LINE_W-1:0] expected_resp(input txn_t e);
    logic [`L15_LINE_W-1:0] line;
    line = ref_line(e.addr);
    if (e.port == `L15_PORT_READ) begin
      return {64'd0, line[`L15_DATA_W-1:0]};
    end
    return line;
  endfunction

  function automatic logic [2:0] rq_for_port(input logic [`L15_PORT_W-1:0] p);
    case (p)
      `L15_PORT_IFILL: return `L15_RQ_IFILL;
      `L15_PORT_READ:  return `L15_RQ_LOAD;
      default:         return `L15_RQ_STORE;
    endcase
  endfunction

  function automatic logic [2:0] rt_for_rq(input logic [2:0] rq);
    case (rq)
      `L15_RQ_IFILL: return `L15_RT_IFILL;
      `L15_RQ_STORE: return `L15_RT_STORE_ACK;
      default:       return `L15_RT_LOAD;
    endcase
  endfunction

  function automatic logic [`L15_TAG_W-1:0] make_tag(input logic [`L15_PORT_W-1:0] p,
                                                     input logic [`L15_ID_W-1:0] id);
    l15_tag_u t;
    t.fields.port = p;
    t.fields.id   = id;
    return t.raw;
  endfunction

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAIL t=%0t %s got=%h expected=%h", $time, name, got, exp);
    end
  endtask

  task automatic report_error(input string what);
    n_errors++;
    $display("Error at %0t: %s", $time, what);
  endtask

  task automatic report_timeout(input string what);
    n_timeouts++;
    $display("Timeout at %0t while waiting for %s", $time, what);
  endtask

  task automatic record_request(input logic [1:0] p, input logic [31:0] a,
                                input logic [2:0] s, input logic [3:0] id,
                                input logic [63:0] d);
    txn_t e;
    e.port = p;
    e.addr = a;
    e.size = s;
    e.id   = id;
    e.data = d;
    issued_q.push_back(e);
    waiting_q.push_back(e);
  endtask

  // Oldest outstanding request of the port owns the response
  task automatic match_response(input logic [1:0] p, input string id_name,
                                input logic [3:0] id, input string data_name,
                                input logic [127:0] data);
    int   idx;
    txn_t e;
    idx = -1;
    foreach (waiting_q[k]) begin
      if (idx < 0 && waiting_q[k].port == p) idx = k;
    end
    if (idx < 0) begin
      report_error($sformatf("response on port %0d with no outstanding request", p));
    end else begin
      e = waiting_q[idx];
      waiting_q.delete(idx);
      check_value(id_name, id, e.id);
      if (p != `L15_PORT_WRITE) check_value(data_name, data, expected_resp(e));
    end
  endtask

  // L1.5 model takes the request held on the port and queues its return
  task automatic accept_request();
    l15_tag_u t;
    int       idx;
    int       delay;
    txn_t     e;
    rtrn_t    r;
    t.raw = l15_tag_o;
    idx   = -1;
    foreach (issued_q[k]) begin
      if (idx < 0 && issued_q[k].port == t.fields.port) idx = k;
    end
    if (idx < 0) begin
      report_error($sformatf("L1.5 request with tag %h matches no accepted request", l15_tag_o));
    end else begin
      e = issued_q[idx];
      issued_q.delete(idx);
      check_value("l15_rqtype_o", l15_rqtype_o, rq_for_port(e.port));
      check_value("l15_size_o", l15_size_o, e.size);
      check_value("l15_address_o", l15_address_o, e.addr);
      check_value("l15_tag_o", l15_tag_o, make_tag(e.port, e.id));
      if (e.port == `L15_PORT_WRITE) begin
        check_value("l15_data_o", l15_data_o, e.data);
        shadow[e.addr] = e.data;
      end
    end
    r.rtype = rt_for_rq(l15_rqtype_o);
    r.tag   = l15_tag_o;
    r.data  = (l15_rqtype_o == `L15_RQ_STORE) ? '0 : ref_line(l15_address_o);
    delay   = 1 + {$random(seed)} % 6;
    r.due   = (cycle_n + delay > last_due) ? cycle_n + delay : last_due + 1;
    last_due = r.due;
    rtrn_q.push_back(r);
  endtask

  // L1.5 model, in-order returns
  always @(posedge clk_i) begin
    #1;
    cycle_n++;
    l15_ack_i      = 1'b0;
    l15_rtrn_val_i = 1'b0;
    if (!rst_i) begin
      if (l15_val_o && rtrn_q.size() >= CREDITS) begin
        report_error("L1.5 request raised while two transactions are outstanding");
      end
      if (rtrn_q.size() != 0 && rtrn_q[0].due <= cycle_n) begin
        rtrn_cur        = rtrn_q.pop_front();
        l15_rtrn_val_i  = 1'b1;
        l15_rtrn_type_i = rtrn_cur.rtype;
        l15_rtrn_tag_i  = rtrn_cur.tag;
        l15_rtrn_data_i = rtrn_cur.data;
      end
      if (l15_val_o) begin
        if (ack_wait < 0) ack_wait = {$random(seed)} % 4;
        if (ack_wait == 0 && rtrn_q.size() < CREDITS) begin
          accept_request();
          l15_ack_i = 1'b1;
          ack_wait  = -1;
        end else if (ack_wait > 0) begin
          ack_wait--;
        end
      end
    end
  end

  // Requester-side monitor and response checker
  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (icache_miss_valid_i && icache_miss_ready_o) begin
        record_request(`L15_PORT_IFILL, icache_miss_paddr_i,
                       icache_miss_nc_i ? 3'd3 : 3'd4, icache_miss_tid_i, '0);
      end
      if (dcache_rd_valid_i && dcache_rd_ready_o) begin
        record_request(`L15_PORT_READ, dcache_rd_addr_i, dcache_rd_size_i,
                       dcache_rd_id_i, '0);
      end
      if (dcache_wr_valid_i && dcache_wr_ready_o) begin
        check_value("dcache_wdata_ready_o", dcache_wdata_ready_o, 1'b1);
        record_request(`L15_PORT_WRITE, dcache_wr_addr_i, dcache_wr_size_i,
                       dcache_wr_id_i, dcache_wdata_i);
      end
      if (icache_resp_valid_o) begin
        match_response(`L15_PORT_IFILL, "icache_resp_tid_o", icache_resp_tid_o,
                       "icache_resp_data_o", icache_resp_data_o);
      end
      if (dcache_rd_resp_valid_o && dcache_rd_resp_ready_i) begin
        match_response(`L15_PORT_READ, "dcache_rd_resp_id_o", dcache_rd_resp_id_o,
                       "dcache_rd_resp_data_o", {64'd0, dcache_rd_resp_data_o});
      end
      if (dcache_wr_resp_valid_o && dcache_wr_resp_ready_i) begin
        match_response(`L15_PORT_WRITE, "dcache_wr_resp_id_o", dcache_wr_resp_id_o,
                       "none", '0);
      end
    end
  end

  // Response readies toggle only during mixed traffic
  always @(posedge clk_i) begin
    #1;
    if (toggle_en) begin
      dcache_rd_resp_ready_i = ({$random(seed)} % 3) != 0;
      dcache_wr_resp_ready_i = ({$random(seed)} % 3) != 0;
    end else begin
      dcache_rd_resp_ready_i = 1'b1;
      dcache_wr_resp_ready_i = 1'b1;
    end
  end

  // Returns one step after the accepting edge
  task automatic wait_accept(input logic [1:0] p, input string what);
    bit accepted;
    int n;
    accepted = 1'b0;
    n        = 0;
    while (!accepted && n < TIMEOUT) begin
      @(posedge clk_i);
      n++;
      case (p)
        `L15_PORT_IFILL: accepted = icache_miss_ready_o;
        `L15_PORT_READ:  accepted = dcache_rd_ready_o;
        default:         accepted = dcache_wr_ready_o;
      endcase
    end
    if (!accepted) report_timeout(what);
    #1;
  endtask

  task automatic wait_drained(input string what);
    int n;
    n = 0;
    while ((issued_q.size() != 0 || waiting_q.size() != 0) && n < TIMEOUT) begin
      @(posedge clk_i);
      #1;
      n++;
    end
    if (issued_q.size() != 0 || waiting_q.size() != 0) report_timeout(what);
  endtask

  task automatic send_ifill(input logic [31:0] addr, input logic nc, input logic [3:0] tid);
    @(posedge clk_i);
    #1;
    icache_miss_valid_i = 1'b1;
    icache_miss_paddr_i = addr;
    icache_miss_nc_i    = nc;
    icache_miss_tid_i   = tid;
    wait_accept(`L15_PORT_IFILL, "icache miss accept");
    icache_miss_valid_i = 1'b0;
  endtask

  task automatic send_read(input logic [31:0] addr, input logic [2:0] size,
                           input logic [3:0] id);
    @(posedge clk_i);
    #1;
    dcache_rd_valid_i = 1'b1;
    dcache_rd_addr_i  = addr;
    dcache_rd_size_i  = size;
    dcache_rd_id_i    = id;
    wait_accept(`L15_PORT_READ, "dcache read accept");
    dcache_rd_valid_i = 1'b0;
  endtask

  // Data strobe follows the request after a few cycles
  task automatic send_write(input logic [31:0] addr, input logic [3:0] id,
                            input logic [63:0] data, input int strobe_delay,
                            input bit expect_quiet);
    @(posedge clk_i);
    #1;
    dcache_wr_valid_i    = 1'b1;
    dcache_wr_addr_i     = addr;
    dcache_wr_size_i     = 3'd3;
    dcache_wr_id_i       = id;
    dcache_wdata_i       = data;
    dcache_wdata_valid_i = 1'b0;
    repeat (strobe_delay) begin
      @(posedge clk_i);
      check_value("dcache_wr_ready_o", dcache_wr_ready_o, 1'b0);
      if (expect_quiet) check_value("l15_val_o", l15_val_o, 1'b0);
      #1;
    end
    dcache_wdata_valid_i = 1'b1;
    wait_accept(`L15_PORT_WRITE, "dcache write accept");
    dcache_wr_valid_i    = 1'b0;
    dcache_wdata_valid_i = 1'b0;
  endtask

  initial begin
    rst_i                = 1'b1;
    icache_miss_valid_i  = 1'b0;
    icache_miss_paddr_i  = '0;
    icache_miss_nc_i     = 1'b0;
    icache_miss_tid_i    = '0;
    dcache_rd_valid_i    = 1'b0;
    dcache_rd_addr_i     = '0;
    dcache_rd_size_i     = '0;
    dcache_rd_id_i       = '0;
    dcache_wr_valid_i    = 1'b0;
    dcache_wr_addr_i     = '0;
    dcache_wr_size_i     = '0;
    dcache_wr_id_i       = '0;
    dcache_wdata_valid_i = 1'b0;
    dcache_wdata_i       = '0;
    repeat (16) @(posedge clk_i);
    #1;
    check_value("l15_val_o", l15_val_o, 1'b0);
    check_value("icache_miss_ready_o", icache_miss_ready_o, 1'b1);
    check_value("icache_resp_valid_o", icache_resp_valid_o, 1'b0);
    check_value("dcache_rd_ready_o", dcache_rd_ready_o, 1'b0);
    check_value("dcache_wr_ready_o", dcache_wr_ready_o, 1'b0);
    check_value("dcache_wdata_ready_o", dcache_wdata_ready_o, 1'b0);
    check_value("dcache_rd_resp_valid_o", dcache_rd_resp_valid_o, 1'b0);
    check_value("dcache_wr_resp_valid_o", dcache_wr_resp_valid_o, 1'b0);
    rst_i = 1'b0;

    // Directed refills, read, write and read-back
    send_ifill(32'h0000_1000, 1'b0, 4'd5);
    wait_drained("cacheable refill");
    send_ifill(32'h0000_2008, 1'b1, 4'd9);
    wait_drained("non-cacheable refill");
    send_read(32'h0000_3010, 3'd3, 4'd3);
    wait_drained("dcache read");
    send_write(32'h0000_4000, 4'd6, 64'hdead_beef_0123_4567, 6, 1'b1);
    wait_drained("dcache write");
    send_read(32'h0000_4000, 3'd3, 4'd7);
    wait_drained("read after write");

    // Mixed traffic from all three ports
    toggle_en = 1'b1;
    fork
      begin
        for (int k = 0; k < N_RAND; k++) begin
          send_ifill(32'h0001_0000 + ({$random(seed)} % 256) * 16,
                     ({$random(seed)} % 2) == 1, 4'(k));
        end
      end
      begin
        for (int k = 0; k < N_RAND; k++) begin
          send_read(32'h0002_0000 + ({$random(seed)} % 256) * 8,
                    3'({$random(seed)} % 4), 4'(k));
        end
      end
      begin
        for (int k = 0; k < N_RAND; k++) begin
          send_write(32'h0003_0000 + ({$random(seed)} % 256) * 8, 4'(k),
                     {$random(seed), $random(seed)}, {$random(seed)} % 4, 1'b0);
        end
      end
    join
    wait_drained("mixed traffic");
    toggle_en = 1'b0;

    $display("Checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+src
src/l15_adapter_pkg.sv
src/l15_mem_if.sv
src/icache_fill_bridge.sv
src/l15_req_arbiter.sv
src/l15_bridge.sv
src/l15_resp_demux.sv
src/l15_adapter_top.sv
tests/tb_l15_adapter.sv
